// ==== test/tdmr_tests.txt ====
# Columns: input word (hex), fault flag, back-pressure flag
# Fault flips bit 0 of the first copy, back-pressure makes ready_i random
0000 0 0
0001 0 0
ffff 0 0
5555 0 0
aaaa 0 0
8000 0 0
1234 1 0
beef 0 0
c0de 0 1
0f0f 0 1
f00d 0 1
7fff 0 1
2468 1 0
1357 0 1
dead 0 1
a5a5 0 0
3c3c 1 0
ffff 0 1
0002 1 0
9abc 0 1
4321 0 0

// ==== project.f ====
+incdir+logic
logic/tdmr_pkg.sv
logic/tdmr_start.sv
logic/tdmr_pipeline.sv
logic/tdmr_end.sv
logic/tdmr_top.sv
test/tdmr_checker.sv
test/tdmr_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tdmr_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps --top-module tdmr_tb -f project.f -o Vtdmr_tb
	./obj_dir/Vtdmr_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/tdmr_tb.sv ====
module tdmr_tb import tdmr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // One line of the tests file
    typedef struct packed {
        data_t word;
        logic  fault;
        logic  bp;
    } test_line_t;

    logic         clk_i = 1'b0;
    logic         rst_ni;
    data_t        data_i;
    logic         valid_i;
    logic         ready_o;
    logic         fault_i;
    tdmr_result_t result_o;
    logic         valid_o;
    logic         ready_i;

    test_line_t   tests[$];
    logic [15:0]  lfsr = 16'd78;
    int           total = 0;
    int           cycle_count = 0;
    int           cycle_limit = 50;
    logic         end_check = 1'b0;
    int           pass_count;
    int           fail_count;
    int           err_count;
    int           out_count;

    always #4 clk_i = ~clk_i;

    tdmr_top DUT (.*);

    tdmr_checker u_checker (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .data_i           (data_i),
        .valid_i          (valid_i),
        .in_ready_i       (ready_o),
        .fault_i          (fault_i),
        .result_i         (result_o),
        .result_valid_i   (valid_o),
        .out_ready_i      (ready_i),
        .expected_total_i (total),
        .end_check_i      (end_check),
        .pass_count_o     (pass_count),
        .fail_count_o     (fail_count),
        .err_count_o      (err_count),
        .out_count_o      (out_count)
    );

    always @(posedge clk_i) begin : timeout_counter
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, not every word came out", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic load_tests(output bit ok);
        int         fd;
        int         n;
        string      line;
        data_t      w;
        logic       f;
        logic       b;
        test_line_t t;
        ok = 1'b0;
        fd = $fopen("test/tdmr_tests.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h", w, f, b);
                if (n == 3) begin
                    t.word  = w;
                    t.fault = f;
                    t.bp    = b;
                    tests.push_back(t);
                end
            end
        end
        $fclose(fd);
        ok = (tests.size() > 0);
    endtask

    task automatic drive_ready(input logic bp);
        if (bp) begin
            lfsr    = lfsr_step(lfsr);
            ready_i = lfsr[0];
        end else begin
            ready_i = 1'b1;
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_word(input test_line_t t);
        data_i  = t.word;
        valid_i = 1'b1;
        drive_ready(t.bp);
        // ready_o follows registered state only, so it is settled here
        while (!ready_o) begin
            @(posedge clk_i);
            #1;
            drive_ready(t.bp);
        end
        if (t.fault) begin
            // Pipeline has to take the first copy in this cycle
            fault_i = 1'b1;
            ready_i = 1'b1;
        end
        @(posedge clk_i);
        #1;
        fault_i = 1'b0;
    endtask

    initial begin : main
        bit ok;
        rst_ni  = 1'b0;
        data_i  = '0;
        valid_i = 1'b0;
        fault_i = 1'b0;
        ready_i = 1'b1;
        load_tests(ok);
        if (!ok) begin
            $display("could not read any test from test/tdmr_tests.txt");
            $display("sim failed");
            $finish;
        end else begin
            total       = tests.size();
            cycle_limit = 16 * total + 50;
            repeat (2) @(posedge clk_i);
            #1;
            rst_ni = 1'b1;
            foreach (tests[i]) begin
                send_word(tests[i]);
            end
            valid_i = 1'b0;
            ready_i = 1'b1;
            while (out_count < total) begin
                @(posedge clk_i);
                #1;
            end
            // Idle cycles so that a late duplicate is still seen
            repeat (8) @(posedge clk_i);
            #1;
            end_check = 1'b1;
            @(posedge clk_i);
            #1;
            $display("%0d tests passed, %0d failed, %0d other errors",
                     pass_count, fail_count, err_count);
            if (fail_count == 0 && err_count == 0 && pass_count == total) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

// ==== test/tdmr_checker.sv ====
module tdmr_checker import tdmr_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  data_t        data_i,
    input  logic         valid_i,
    input  logic         in_ready_i,
    input  logic         fault_i,
    input  tdmr_result_t result_i,
    input  logic         result_valid_i,
    input  logic         out_ready_i,
    input  int           expected_total_i,
    input  logic         end_check_i,
    output int           pass_count_o,
    output int           fail_count_o,
    output int           err_count_o,
    output int           out_count_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // Accepted word waiting for its result
    typedef struct packed {
        data_t word;
        data_t expected;
        logic  fault;
    } pending_t;

    pending_t     pending[$];
    pending_t     head;
    data_t        product;
    tdmr_result_t held_result;
    logic         holding = 1'b0;
    logic         prev_accept = 1'b0;
    logic         reset_checked = 1'b0;
    logic         ended = 1'b0;
    logic         ok;
    int           in_count = 0;
    int           out_count = 0;
    int           pass_count = 0;
    int           fail_count = 0;
    int           err_count = 0;

    assign pass_count_o = pass_count;
    assign fail_count_o = fail_count;
    assign err_count_o  = err_count;
    assign out_count_o  = out_count;

    always @(posedge clk_i) begin : monitor
        if (rst_ni) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (result_valid_i !== 1'b0) begin
                    $display("MISMATCH after reset valid_o expected %h actual %h",
                             1'b0, result_valid_i);
                    err_count++;
                end
                if (in_ready_i !== 1'b1) begin
                    $display("MISMATCH after reset ready_o expected %h actual %h",
                             1'b1, in_ready_i);
                    err_count++;
                end
            end

            // Input side takes at most one word every two cycles
            if (valid_i && in_ready_i && prev_accept) begin
                $display("input words were accepted on two consecutive cycles");
                err_count++;
            end
            prev_accept = valid_i && in_ready_i;
            if (valid_i && in_ready_i) begin
                // Times three wraps at 16 bits, then the key
                product = data_i * 16'd3;
                pending.push_back('{data_i, product ^ 16'hA5A5, fault_i});
                in_count++;
            end

            if (holding && (!result_valid_i || result_i !== held_result)) begin
                $display("result_o changed before ready_i took it, held %h now %h",
                         held_result, result_i);
                err_count++;
            end
            holding     = result_valid_i && !out_ready_i;
            held_result = result_i;

            if (result_valid_i && out_ready_i) begin
                out_count++;
                if (pending.size() == 0) begin
                    $display("output %h arrived with no input word waiting for it",
                             result_i.data);
                    err_count++;
                end else begin
                    head = pending.pop_front();
                    ok   = 1'b1;
                    if (result_i.data !== head.expected) begin
                        $display("MISMATCH test %0d result_o.data expected %h actual %h",
                                 out_count, head.expected, result_i.data);
                        ok = 1'b0;
                    end
                    if (result_i.error !== head.fault) begin
                        $display("MISMATCH test %0d result_o.error expected %h actual %h",
                                 out_count, head.fault, result_i.error);
                        ok = 1'b0;
                    end
                    if (ok) begin
                        $display("test %0d ok: in %h out %h error %h",
                                 out_count, head.word, result_i.data, result_i.error);
                        pass_count++;
                    end else begin
                        $display("test %0d failed: in %h", out_count, head.word);
                        fail_count++;
                    end
                end
            end

            if (end_check_i && !ended) begin
                ended = 1'b1;
                if (in_count != expected_total_i) begin
                    $display("%0d words were accepted but the tests file has %0d",
                             in_count, expected_total_i);
                    err_count++;
                end
                if (out_count != in_count) begin
                    $display("%0d results came out for %0d accepted words",
                             out_count, in_count);
                    err_count++;
                end
            end
        end
    end

endmodule

// ==== logic/tdmr_top.sv ====
module tdmr_top import tdmr_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,

    input  data_t        data_i,
    input  logic         valid_i,
    output logic         ready_o,

    input  logic         fault_i,

    output tdmr_result_t result_o,
    output logic         valid_o,
    input  logic         ready_i
);

    tdmr_item_t start_item, pipe_item;
    logic       start_valid, start_ready;
    logic       pipe_valid, pipe_ready;

    tdmr_start u_start (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .data_i  (data_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .item_o  (start_item),
        .valid_o (start_valid),
        .ready_i (start_ready)
    );

    tdmr_pipeline u_pipeline (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .item_i  (start_item),
        .valid_i (start_valid),
        .ready_o (start_ready),
        .fault_i (fault_i),
        .item_o  (pipe_item),
        .valid_o (pipe_valid),
        .ready_i (pipe_ready)
    );

    tdmr_end u_end (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .item_i   (pipe_item),
        .valid_i  (pipe_valid),
        .ready_o  (pipe_ready),
        .result_o (result_o),
        .valid_o  (valid_o),
        .ready_i  (ready_i)
    );

endmodule

// ==== logic/tdmr_end.sv ====
`include "voters.svh"

module tdmr_end import tdmr_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,

    // From the pipeline
    input  tdmr_item_t   item_i,
    input  logic         valid_i,
    output logic         ready_o,

    // Downstream
    output tdmr_result_t result_o,
    output logic         valid_o,
    input  logic         ready_i
);

    logic [2:0]   state_v, state_d, state_q;
    logic         state_cur;
    logic         take;
    logic         pair_done;
    logic         mismatch;
    tdmr_item_t   first_q;
    tdmr_result_t result_q;
    logic         result_valid_q;

    // Hold off the pipeline while a result is still pending
    assign ready_o = ~result_valid_q | ready_i;
    assign take    = valid_i & ready_o;

    // Second copy arriving completes a pair
    assign pair_done = take & (state_cur == END_WAIT_SECOND);

    // Any difference in data or id means one copy was hit
    assign mismatch = (item_i.data != first_q.data) | (item_i.id != first_q.id);

    always_comb begin : next_state_logic
        for (int r = 0; r < 3; r++) begin
            state_v[r] = state_q[r];
            if (take) begin
                if (state_q[r] == END_WAIT_FIRST) begin
                    state_v[r] = END_WAIT_SECOND;
                end else begin
                    state_v[r] = END_WAIT_FIRST;
                end
            end
        end
    end

    always_comb begin : voting_logic
        `VOTE3TO3(state_v, state_d);
        `VOTE3TO1(state_q, state_cur);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            state_q        <= {3{END_WAIT_FIRST}};
            result_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (pair_done) begin
                result_valid_q <= 1'b1;
            end else if (ready_i) begin
                result_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin : data_ff
        if (take && state_cur == END_WAIT_FIRST) begin
            first_q <= item_i;
        end
        // The second copy supplies the data word
        if (pair_done) begin
            result_q.data  <= item_i.data;
            result_q.error <= mismatch;
        end
    end

    assign result_o = result_q;
    assign valid_o  = result_valid_q;

endmodule

// ==== logic/tdmr_pipeline.sv ====
module tdmr_pipeline import tdmr_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,

    input  tdmr_item_t item_i,
    input  logic       valid_i,
    output logic       ready_o,

    // Flips bit 0 of the value stored in stage 1
    input  logic       fault_i,

    output tdmr_item_t item_o,
    output logic       valid_o,
    input  logic       ready_i
);

    tdmr_item_t s1_next, s2_next;
    tdmr_item_t s1_q, s2_q;
    logic       s1_valid_q, s2_valid_q;
    logic       s1_en, s2_en;

    // A stage moves when it is empty or the stage after it moves
    assign s2_en   = ~s2_valid_q | ready_i;
    assign s1_en   = ~s1_valid_q | s2_en;
    assign ready_o = s1_en;

    always_comb begin : stage_logic
        s1_next         = item_i;
        s1_next.data    = (item_i.data << 1) + item_i.data;
        s1_next.data[0] = s1_next.data[0] ^ fault_i;

        s2_next      = s1_q;
        s2_next.data = s1_q.data ^ PIPE_KEY;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_ff
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_en) begin
                s1_valid_q <= valid_i;
            end
            if (s2_en) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin : data_ff
        if (s1_en && valid_i) begin
            s1_q <= s1_next;
        end
        if (s2_en && s1_valid_q) begin
            s2_q <= s2_next;
        end
    end

    assign item_o  = s2_q;
    assign valid_o = s2_valid_q;

endmodule

// ==== logic/tdmr_start.sv ====
`include "voters.svh"

module tdmr_start import tdmr_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,

    // Upstream
    input  data_t      data_i,
    input  logic       valid_i,
    output logic       ready_o,

    // Towards the pipeline
    output tdmr_item_t item_o,
    output logic       valid_o,
    input  logic       ready_i
);

    logic [2:0][1:0]          state_v, state_d, state_q;
    logic [1:0]               state_cur;
    data_t [2:0]              data_d, data_q;
    id_t [2:0]                id_v, id_d, id_q, id_next;
    logic [2:0][ID_WIDTH-2:0] cnt_next;

    // Each copy works out its own next state from its own stored state
    always_comb begin : next_state_logic
        for (int r = 0; r < 3; r++) begin
            state_v[r] = state_q[r];
            data_d[r]  = data_q[r];
            id_v[r]    = id_q[r];

            // Counter step with fresh parity on top
            cnt_next[r] = id_q[r][ID_WIDTH-2:0] + (ID_WIDTH-1)'(1);
            id_next[r]  = {^cnt_next[r], cnt_next[r]};

            case (state_q[r])
                ST_STORE_AND_SEND: begin
                    if (valid_i) begin
                        data_d[r] = data_i;
                        id_v[r]   = id_next[r];
                        // First copy goes out right away if the pipeline takes it
                        state_v[r] = ready_i ? ST_REPLICATE : ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (ready_i) begin
                        state_v[r] = ST_REPLICATE;
                    end
                end
                ST_REPLICATE: begin
                    if (ready_i) begin
                        state_v[r] = ST_STORE_AND_SEND;
                    end
                end
                default: begin
                    state_v[r] = ST_STORE_AND_SEND;
                end
            endcase
        end
    end

    always_comb begin : voting_logic
        `VOTE3TO3(state_v, state_d);
        `VOTE3TO3(id_v, id_d);
        `VOTE3TO1(state_q, state_cur);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            state_q <= {3{ST_STORE_AND_SEND}};
            id_q    <= '0;
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
        end
    end

    always_ff @(posedge clk_i) begin : data_ff
        data_q <= data_d;
    end

    // Idle passes the upstream valid through, otherwise the stored word is offered
    always_comb begin : output_logic
        case (state_cur)
            ST_STORE_AND_SEND: begin
                valid_o = valid_i;
                ready_o = 1'b1;
            end
            default: begin
                valid_o = 1'b1;
                ready_o = 1'b0;
            end
        endcase
    end

    always_comb begin : output_voters
        `VOTE3TO1(data_d, item_o.data);
        `VOTE3TO1(id_v, item_o.id);
    end

endmodule

// ==== logic/tdmr_pkg.sv ====
package tdmr_pkg;

    // Word and sequence id widths
    localparam int unsigned DATA_WIDTH = 16;
    localparam int unsigned ID_WIDTH   = 3;

    // Constant mixed into every word by the second pipeline stage
    localparam logic [DATA_WIDTH-1:0] PIPE_KEY = 16'hA5A5;

    // Input side FSM encoding
    localparam logic [1:0] ST_STORE_AND_SEND = 2'd0;
    localparam logic [1:0] ST_SEND           = 2'd1;
    localparam logic [1:0] ST_REPLICATE      = 2'd2;

    // Output side pairing state
    localparam logic END_WAIT_FIRST  = 1'b0;
    localparam logic END_WAIT_SECOND = 1'b1;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // Top bit is the parity of the counter bits below it
    typedef logic [ID_WIDTH-1:0] id_t;

    // One copy of a word on its way through the pipeline
    typedef struct packed {
        data_t data;
        id_t   id;
    } tdmr_item_t;

    // Paired result leaving the channel
    typedef struct packed {
        data_t data;
        logic  error;
    } tdmr_result_t;

endpackage

// ==== logic/voters.svh ====
`ifndef VOTERS_SVH
`define VOTERS_SVH

// Bitwise majority of three copies, written back into three copies
// Arguments are arrays indexed 0 to 2
`define VOTE3TO3(in_v, out_v) \
    out_v[0] = (in_v[0] & in_v[1]) | (in_v[1] & in_v[2]) | (in_v[0] & in_v[2]); \
    out_v[1] = (in_v[0] & in_v[1]) | (in_v[1] & in_v[2]) | (in_v[0] & in_v[2]); \
    out_v[2] = (in_v[0] & in_v[1]) | (in_v[1] & in_v[2]) | (in_v[0] & in_v[2])

// Bitwise majority of three copies into a single value
`define VOTE3TO1(in_v, out_s) \
    out_s = (in_v[0] & in_v[1]) | (in_v[1] & in_v[2]) | (in_v[0] & in_v[2])

`endif
